// File: rs485Pkg.sv
`default_nettype none

package rs485Pkg;

	typedef logic [8:0] memAddr;	// frame memory address
	typedef logic [7:0] memByte;	// frame memory data

	// one byte on its way from fetcher to serializer
	typedef struct packed {
		logic [7:0] data;
		logic last;	// final byte of the frame
	} txByte;

	typedef enum logic [0:0] {
		selSetup = 1'b0,	// frameSetup view
		selTiming = 1'b1	// lineTiming view
	} cfgSel;

	// one host config word read in two ways
	typedef union packed {
		struct packed {
			logic [4:0] byteCount;	// 1..31 with zero ignored
			logic [10:0] reserved;
		} frameSetup;
		struct packed {
			logic [7:0] dirLead;	// dirRX to dirTX delay
			logic [7:0] dirTail;	// dirTX to dirRX delay
		} lineTiming;
	} cfgWord;

	typedef struct packed {
		logic [7:0] dirLead;
		logic [7:0] dirTail;
	} lineCfg;

	localparam logic [4:0] DEF_BYTE_COUNT = 5'd4;	// bytes per frame
	localparam logic [7:0] DEF_DIR_LEAD = 8'd15;	// cycles
	localparam logic [7:0] DEF_DIR_TAIL = 8'd4;	// cycles

endpackage

`default_nettype wire

// File: txConfig.sv
`default_nettype none

module txConfig import rs485Pkg::*; (
	input logic edgeTx,
	input logic reset,
	input logic cfgWe,	// one-cycle write strobe
	input rs485Pkg::cfgSel cfgSel,	// which view of cfgData
	input cfgWord cfgData,
	output logic [4:0] byteCount,
	output lineCfg timing
);

	logic setupWr;	// frameSetup write
	logic timingWr;	// lineTiming write
	logic countOk;	// nonzero byte count

	assign setupWr = cfgWe && (cfgSel == selSetup);
	assign timingWr = cfgWe && (cfgSel == selTiming);
	assign countOk = (cfgData.frameSetup.byteCount != 5'd0);

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			byteCount <= DEF_BYTE_COUNT;
		end else if (setupWr && countOk) begin
			byteCount <= cfgData.frameSetup.byteCount;	// zero count keeps old value
		end
	end

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			timing.dirLead <= DEF_DIR_LEAD;
			timing.dirTail <= DEF_DIR_TAIL;
		end else if (timingWr) begin
			timing.dirLead <= cfgData.lineTiming.dirLead;	// upper byte
			timing.dirTail <= cfgData.lineTiming.dirTail;	// lower byte
		end
	end

endmodule

`default_nettype wire

// File: frameMemory.sv
`default_nettype none

module frameMemory import rs485Pkg::*; (
	input logic edgeTx,
	input logic memWe,	// host write strobe
	input memAddr memWrAddr,
	input memByte memWrData,
	input logic rdEn,	// fetcher read strobe
	input memAddr rdAddr,
	output memByte rdData	// valid one cycle after rdEn
);

	memByte mem [512];	// frame store, host filled

	always_ff @(posedge edgeTx) begin
		if (memWe) begin
			mem[memWrAddr] <= memWrData;
		end
	end

	// registered read that holds between reads
	always_ff @(posedge edgeTx) begin
		if (rdEn) begin
			rdData <= mem[rdAddr];
		end
	end

endmodule

`default_nettype wire

// File: byteFetcher.sv
`default_nettype none

module byteFetcher import rs485Pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input logic edgeTx,
	input logic reset,
	input logic frameStart,	// pulse from serializer
	input logic [5:0] cycle,	// selects the frame slot
	input logic [4:0] byteCount,
	input logic creditReturn,	// serializer popped one byte
	input memByte rdData,
	output logic rdEn,
	output memAddr rdAddr,
	output logic byteValid,
	output txByte byteOut
);

	localparam int CW = $clog2(QUEUE_DEPTH + 1);	// credit counter width

	logic [CW-1:0] credits;	// free queue slots
	memAddr baseAddr;	// cycle*4
	logic [4:0] index;	// byte within frame
	logic [4:0] remaining;	// reads still to issue
	logic lastRead;
	logic rdPend;	// read issued last cycle
	logic lastPend;	// that read was the final one

	assign lastRead = (remaining == 5'd1);
	assign rdEn = (credits != '0) && (remaining != 5'd0);	// stall on zero credits
	assign rdAddr = baseAddr + memAddr'(index);

	// push lines up with memory latency
	assign byteValid = rdPend;
	assign byteOut.data = rdData;
	assign byteOut.last = lastPend;

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			credits <= CW'(QUEUE_DEPTH);	// queue starts empty
		end else begin
			case ({rdEn, creditReturn})
				2'b10: credits <= credits - 1'b1;	// read spends one
				2'b01: credits <= credits + 1'b1;	// pop gives one back
				default: credits <= credits;	// both or neither
			endcase
		end
	end

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			baseAddr <= '0;
			index <= 5'd0;
			remaining <= 5'd0;
			rdPend <= 1'b0;
			lastPend <= 1'b0;
		end else begin
			rdPend <= rdEn;
			if (frameStart) begin
				baseAddr <= {1'b0, cycle, 2'b00};	// slot base
				index <= 5'd0;
				remaining <= byteCount;
			end else if (rdEn) begin
				index <= index + 1'b1;
				remaining <= remaining - 1'b1;
				lastPend <= lastRead;	// tag for the push
			end
		end
	end

endmodule

`default_nettype wire

// File: lineSerializer.sv
`default_nettype none

module lineSerializer import rs485Pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input logic edgeTx,
	input logic reset,
	input logic rq,	// async request level
	input lineCfg timing,
	input logic byteValid,
	input txByte byteIn,
	output logic frameStart,
	output logic creditReturn,
	output logic tx,
	output logic dirTX,
	output logic dirRX,
	output logic frameDone
);

	localparam logic [2:0] idle = 3'd0;
	localparam logic [2:0] lead = 3'd1;
	localparam logic [2:0] send = 3'd2;
	localparam logic [2:0] tail = 3'd3;
	localparam logic [2:0] done = 3'd4;
	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;	// pointer width
	localparam int CW = $clog2(QUEUE_DEPTH + 1);	// fill width

	logic [2:0] state;
	logic [1:0] rqSync;	// two-flop synchronizer
	logic [7:0] dirCnt;	// lead and tail countdown
	logic [7:0] tailLen;	// latched at frame start
	txByte queue [QUEUE_DEPTH];
	txByte head;
	logic [PW-1:0] wrPtr;
	logic [PW-1:0] rdPtr;
	logic [CW-1:0] fill;
	logic [7:0] shifter;	// data bits, LSB out first
	logic [3:0] bitCnt;	// 0 start, 1..8 data, 9 stop
	logic busy;	// a byte is on the line
	logic lastByte;	// byte on the line ends the frame
	logic stopEnd;	// last cycle of a stop bit
	logic pop;

	function automatic logic [PW-1:0] nextPtr(input logic [PW-1:0] p);
		nextPtr = (p == PW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;	// wrap
	endfunction

	assign head = queue[rdPtr];
	assign stopEnd = busy && (bitCnt == 4'd9);
	// back-to-back pop right after a stop bit
	assign pop = (state == send) && (fill != '0) && (!busy || (stopEnd && !lastByte));
	assign creditReturn = pop;

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			rqSync <= 2'b00;
		end else begin
			rqSync <= {rqSync[0], rq};
		end
	end

	always_ff @(posedge edgeTx) begin
		if (byteValid) begin
			queue[wrPtr] <= byteIn;	// credits guarantee room
		end
	end

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
		end else begin
			if (byteValid) wrPtr <= nextPtr(wrPtr);
			if (pop) rdPtr <= nextPtr(rdPtr);
			case ({byteValid, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge edgeTx) begin
		if (pop) begin
			shifter <= head.data;
		end else if (busy && bitCnt < 4'd8) begin
			shifter <= shifter >> 1;	// next data bit to lsb
		end
	end

	// bit sequencer of 10 cycles per byte
	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			tx <= 1'b1;
			busy <= 1'b0;
			bitCnt <= 4'd0;
			lastByte <= 1'b0;
		end else if (pop) begin
			tx <= 1'b0;	// start bit
			busy <= 1'b1;
			bitCnt <= 4'd0;
			lastByte <= head.last;
		end else if (busy) begin
			if (bitCnt < 4'd8) begin
				tx <= shifter[0];
				bitCnt <= bitCnt + 1'b1;
			end else if (bitCnt == 4'd8) begin
				tx <= 1'b1;	// stop bit
				bitCnt <= 4'd9;
			end else begin
				busy <= 1'b0;	// line idles high
			end
		end
	end

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			state <= idle;
			frameStart <= 1'b0;
			dirTX <= 1'b0;
			dirRX <= 1'b0;
			frameDone <= 1'b0;
			dirCnt <= 8'd0;
			tailLen <= 8'd0;
		end else begin
			frameStart <= 1'b0;
			case (state)
				idle: begin
					if (rqSync[1]) begin
						frameStart <= 1'b1;
						dirRX <= 1'b1;
						dirCnt <= timing.dirLead;
						tailLen <= timing.dirTail;	// config frozen for this frame
						if (timing.dirLead == 8'd0) begin
							dirTX <= 1'b1;	// no lead time
							state <= send;
						end else begin
							state <= lead;
						end
					end
				end
				lead: begin
					if (dirCnt == 8'd1) begin
						dirTX <= 1'b1;
						state <= send;
					end else begin
						dirCnt <= dirCnt - 1'b1;
					end
				end
				send: begin
					if (stopEnd && lastByte) begin
						dirTX <= 1'b0;	// right after last stop bit
						if (tailLen == 8'd0) begin
							dirRX <= 1'b0;
							frameDone <= 1'b1;
							state <= done;
						end else begin
							dirCnt <= tailLen;
							state <= tail;
						end
					end
				end
				tail: begin
					if (dirCnt == 8'd1) begin
						dirRX <= 1'b0;
						frameDone <= 1'b1;
						state <= done;
					end else begin
						dirCnt <= dirCnt - 1'b1;
					end
				end
				done: begin
					if (!rqSync[1]) begin	// wait for host to drop rq
						frameDone <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rs485Top.sv
`default_nettype none

module rs485Top import rs485Pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input logic edgeTx,	// bit clock
	input logic reset,
	input logic rq,
	input logic [5:0] cycle,
	input logic cfgWe,
	input rs485Pkg::cfgSel cfgSel,
	input cfgWord cfgData,
	input logic memWe,
	input memAddr memWrAddr,
	input memByte memWrData,
	output logic tx,
	output logic dirTX,
	output logic dirRX,
	output logic frameDone
);

	logic [4:0] byteCount;
	lineCfg timing;
	logic rdEn;
	memAddr rdAddr;
	memByte rdData;
	logic byteValid;
	txByte fetchByte;	// fetcher to serializer queue
	logic frameStart;
	logic creditReturn;

	txConfig uConfig (
		.edgeTx(edgeTx),
		.reset(reset),
		.cfgWe(cfgWe),
		.cfgSel(cfgSel),
		.cfgData(cfgData),
		.byteCount(byteCount),
		.timing(timing)
	);

	frameMemory uMemory (
		.edgeTx(edgeTx),
		.memWe(memWe),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	byteFetcher #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) uFetcher (
		.edgeTx(edgeTx),
		.reset(reset),
		.frameStart(frameStart),
		.cycle(cycle),
		.byteCount(byteCount),
		.creditReturn(creditReturn),
		.rdData(rdData),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.byteValid(byteValid),
		.byteOut(fetchByte)
	);

	lineSerializer #(
		.QUEUE_DEPTH(QUEUE_DEPTH)	// sizes queue and credits alike
	) uSerializer (
		.edgeTx(edgeTx),
		.reset(reset),
		.rq(rq),
		.timing(timing),
		.byteValid(byteValid),
		.byteIn(fetchByte),
		.frameStart(frameStart),
		.creditReturn(creditReturn),
		.tx(tx),
		.dirTX(dirTX),
		.dirRX(dirRX),
		.frameDone(frameDone)
	);

endmodule

`default_nettype wire

// File: rs485Tx_chk.sv
`default_nettype none

module rs485Chk (
	input logic edgeTx,
	input logic reset,
	input logic tx,
	input logic dirTX,
	input logic dirRX,
	input logic frameDone
);

	// line idles high whenever the driver is off
	idleHigh: assert property (@(posedge edgeTx) disable iff (!reset) !dirTX |-> tx)
		else $error("tx low with driver disabled");

	// driver only on inside the receiver window
	dirOrder: assert property (@(posedge edgeTx) disable iff (!reset) dirTX |-> dirRX)
		else $error("dirTX high without dirRX");

	doneQuiet: assert property (@(posedge edgeTx) disable iff (!reset) !(frameDone && dirTX))
		else $error("frameDone high while driving");	// done only after tail

endmodule

bind rs485Top rs485Chk uChk (
	.edgeTx(edgeTx),
	.reset(reset),
	.tx(tx),
	.dirTX(dirTX),
	.dirRX(dirRX),
	.frameDone(frameDone)
);

`default_nettype wire

// File: rs485Tb.sv
`default_nettype none

module rs485Tb import rs485Pkg::*; ();

	localparam int NUM_FRAMES = 12;
	localparam int RESET_FRAME = 8;	// frame cut short by reset
	localparam int ZERO_FRAME = 3;	// frame that writes byteCount zero
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (2 + 255 + 255 + 31 * 12 + 40);

	logic edgeTx;
	logic reset;
	logic rq;
	logic [5:0] cycle;
	logic cfgWe;
	cfgSel cfgView;
	cfgWord cfgData;
	logic memWe;
	memAddr memWrAddr;
	memByte memWrData;
	logic tx;
	logic dirTX;
	logic dirRX;
	logic frameDone;

	int seed = 55;
	int errorCount = 0;
	int cycleCnt = 0;
	memByte mirror [512];	// model of the frame store
	logic [4:0] expCount;
	logic [7:0] expLead;
	logic [7:0] expTail;

	memByte rxBytes [$];	// bytes seen on the line
	logic inByte;
	int bitIdx;
	memByte shiftIn;
	int sampleCnt;
	int rxRiseAt;
	int txFallAt;
	int leadMeas;	// dirRX rise to dirTX rise
	int tailMeas;	// dirTX fall to dirRX fall
	logic prevDirRX;
	logic prevDirTX;

	rs485Top #(
		.QUEUE_DEPTH(2)
	) u_dut (
		.edgeTx(edgeTx),
		.reset(reset),
		.rq(rq),
		.cycle(cycle),
		.cfgWe(cfgWe),
		.cfgSel(cfgView),
		.cfgData(cfgData),
		.memWe(memWe),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.tx(tx),
		.dirTX(dirTX),
		.dirRX(dirRX),
		.frameDone(frameDone)
	);

	initial begin
		edgeTx = 1'b0;
		forever #5 edgeTx = ~edgeTx;
	end

	always @(posedge edgeTx) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TIMEOUT_CYCLES) begin
			$display("timeout: frame never completed");
			$display("Testbench failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic reportFail(input string msg);
		errorCount++;
		$display("FAIL at time %0t: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkByte(input memByte exp, input memByte act, input int idx);
		if (act !== exp) begin
			reportFail($sformatf("byte %0d expected %h got %h", idx, exp, act));
		end
	endtask

	task automatic checkDirCount(input logic [7:0] exp, input logic [7:0] meas,
			input string which);
		if (meas !== exp) begin
			reportFail($sformatf("%s count expected %0d got %0d", which, exp, meas));
		end
	endtask

	task automatic checkFrameLen(input logic [4:0] exp, input logic [4:0] got);
		if (got !== exp) begin
			reportFail($sformatf("frame length expected %0d got %0d", exp, got));
		end
	endtask

	task automatic checkLevel(input string what, input logic exp, input logic act);
		if (act !== exp) reportFail($sformatf("%s expected %b got %b", what, exp, act));
	endtask

	// line decoder and direction timing sampled mid-cycle
	always @(negedge edgeTx) begin
		if (!reset) begin
			inByte = 1'b0;
			bitIdx = 0;
			rxBytes.delete();
			prevDirRX = 1'b0;
			prevDirTX = 1'b0;
			sampleCnt = 0;
		end else begin
			sampleCnt = sampleCnt + 1;
			if (!dirTX) checkLevel("tx with driver off", 1'b1, tx);
			if (dirTX) checkLevel("dirRX while driving", 1'b1, dirRX);
			if (dirTX) checkLevel("frameDone while driving", 1'b0, frameDone);
			if (dirRX && !prevDirRX) rxRiseAt = sampleCnt;
			if (dirTX && !prevDirTX) leadMeas = sampleCnt - rxRiseAt;
			if (!dirTX && prevDirTX) txFallAt = sampleCnt;
			if (!dirRX && prevDirRX) begin
				tailMeas = sampleCnt - txFallAt;	// same sample when tail is 0
				checkLevel("frameDone at dirRX fall", 1'b1, frameDone);
			end
			if (dirTX) begin
				if (!inByte) begin
					if (tx == 1'b0) begin
						inByte = 1'b1;	// start bit
						bitIdx = 0;
					end
				end else if (bitIdx < 8) begin
					shiftIn[bitIdx] = tx;	// lsb first
					bitIdx = bitIdx + 1;
				end else begin
					inByte = 1'b0;
					checkLevel("stop bit", 1'b1, tx);
					rxBytes.push_back(shiftIn);
				end
			end
			prevDirRX = dirRX;
			prevDirTX = dirTX;
		end
	end

	task automatic writeConfig(input cfgSel sel, input cfgWord word);
		@(negedge edgeTx);
		cfgWe <= 1'b1;
		cfgView <= sel;
		cfgData <= word;
		@(negedge edgeTx);
		cfgWe <= 1'b0;
	endtask

	task automatic newConfig(input logic forceZero);
		logic [31:0] r;
		logic [4:0] count;
		cfgWord word;
		r = $random(seed);
		count = forceZero ? 5'd0 : r[4:0];
		word.frameSetup.byteCount = count;
		word.frameSetup.reserved = r[15:5];	// junk in unused bits
		writeConfig(selSetup, word);
		if (count != 5'd0) expCount = count;	// zero keeps old count
		r = $random(seed);
		word.lineTiming.dirLead = r[7:0];
		word.lineTiming.dirTail = r[15:8];
		writeConfig(selTiming, word);
		expLead = r[7:0];
		expTail = r[15:8];
	endtask

	// frame bytes plus one spare past the end
	task automatic fillSlot(input logic [5:0] slot);
		int i;
		int addr;
		logic [31:0] r;
		for (i = 0; i <= expCount; i++) begin
			r = $random(seed);
			addr = slot * 4 + i;
			@(negedge edgeTx);
			memWe <= 1'b1;
			memWrAddr <= memAddr'(addr);
			memWrData <= r[7:0];
			mirror[addr] = r[7:0];
		end
		@(negedge edgeTx);
		memWe <= 1'b0;
	endtask

	task automatic runFrame(input logic [5:0] slot);
		int hold;
		int i;
		int base;
		base = slot * 4;
		@(negedge edgeTx);
		rq <= 1'b1;
		while (frameDone !== 1'b1) @(negedge edgeTx);
		hold = 2 + ($random(seed) & 7);
		repeat (hold) begin
			@(negedge edgeTx);
			checkLevel("dirRX with rq held", 1'b0, dirRX);	// no second frame
			checkLevel("frameDone with rq held", 1'b1, frameDone);
		end
		rq <= 1'b0;
		while (frameDone !== 1'b0) @(negedge edgeTx);
		@(posedge edgeTx);
		if (rxBytes.size() > 31) reportFail("more than 31 bytes seen on the line");
		checkFrameLen(expCount, 5'(rxBytes.size()));
		for (i = 0; i < rxBytes.size(); i++) begin
			checkByte(mirror[base + i], rxBytes[i], i);
		end
		checkDirCount(expLead, 8'(leadMeas), "lead");
		checkDirCount(expTail, 8'(tailMeas), "tail");
		rxBytes.delete();
	endtask

	task automatic abortFrame();
		int delay;
		@(negedge edgeTx);
		rq <= 1'b1;
		while (dirTX !== 1'b1) @(negedge edgeTx);
		delay = 1 + ($random(seed) & 7);
		repeat (delay) @(negedge edgeTx);
		reset <= 1'b0;	// mid-frame
		rq <= 1'b0;
		@(negedge edgeTx);
		checkLevel("tx in reset", 1'b1, tx);
		checkLevel("dirTX in reset", 1'b0, dirTX);
		checkLevel("dirRX in reset", 1'b0, dirRX);
		checkLevel("frameDone in reset", 1'b0, frameDone);
		repeat (3) @(negedge edgeTx);
		reset <= 1'b1;
		expCount = DEF_BYTE_COUNT;	// config back to defaults
		expLead = DEF_DIR_LEAD;
		expTail = DEF_DIR_TAIL;
		@(posedge edgeTx);
		rxBytes.delete();
	endtask

	initial begin
		int frame;
		logic [31:0] r;
		reset <= 1'b0;
		rq <= 1'b0;
		cycle <= 6'd0;
		cfgWe <= 1'b0;
		cfgView <= selSetup;
		cfgData <= '0;
		memWe <= 1'b0;
		memWrAddr <= '0;
		memWrData <= '0;
		expCount = DEF_BYTE_COUNT;
		expLead = DEF_DIR_LEAD;
		expTail = DEF_DIR_TAIL;
		repeat (4) @(negedge edgeTx);
		reset <= 1'b1;
		for (frame = 0; frame < NUM_FRAMES; frame++) begin
			r = $random(seed);
			@(negedge edgeTx);
			cycle <= r[5:0];	// slot base cycle*4
			if (frame > 0 && frame != RESET_FRAME + 1) begin
				newConfig(frame == ZERO_FRAME);
			end
			fillSlot(r[5:0]);
			if (frame == RESET_FRAME) begin
				abortFrame();
			end else begin
				runFrame(r[5:0]);
			end
		end
		if (errorCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// File: compile.f
rs485Pkg.sv
txConfig.sv
frameMemory.sv
byteFetcher.sv
lineSerializer.sv
rs485Top.sv
rs485Tx_chk.sv
rs485Tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --assert -Wno-fatal --top-module rs485Tb -f compile.f &&
	./obj_dir/Vrs485Tb | grep -F "Testbench passed" ||
	exit 1
